/* hw/videoCard_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// constants for the 640x480 card, one pixel per clock
// every window below is half open, end value excluded
// register indices are the host protocol's byte values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef VIDEOCARD_DEFS_SVH
`define VIDEOCARD_DEFS_SVH

// horizontal timing in clocks
`define H_VISIBLE       640
`define H_SYNC_START    656
`define H_SYNC_END      752
`define H_TOTAL         800

// vertical timing in lines
`define V_VISIBLE       480
`define V_SYNC_START    490
`define V_SYNC_END      492
`define V_TOTAL         525

// bus owned by the write side
`define BUS_H_START     642
`define BUS_H_END       799
`define BUS_V_START     482
`define BUS_V_END       524

// a write may only begin inside this shorter window
`define GRANT_H_END     785
`define GRANT_V_END     510

`define WRITE_CYCLES    10      // chip enable low
`define WE_LOW_CYCLES   6       // write enable low, at the start

`define REG_ADDR0       8'hB0   // pointer bits 7:0
`define REG_ADDR1       8'hB1   // pointer bits 15:8
`define REG_ADDR2       8'hB2   // pointer bits 19:16
`define REG_CONTROL     8'hB3   // bit 0 selects vram display
`define REG_PIXEL       8'hB4   // two bytes, low first

`endif

/* hw/videoTimingPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// screen position and sync types
// counts are raw clock and line numbers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package videoTimingPkg;

    // where the beam is right now
    typedef struct packed {
        logic [10:0] hCount;    // 0..799
        logic [9:0]  vCount;    // 0..524
    } screenPos_t;

    // registered one clock behind the position
    typedef struct packed {
        logic hsync;            // active low
        logic vsync;            // active low
        logic visible;          // inside 640x480
    } syncOut_t;

endpackage

`default_nettype wire

/* hw/vramBusPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel, sram bus and write request types
// sram is 16 bits wide with byte addresses
// so pixel addresses step by 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package vramBusPkg;

    // rgb565, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    typedef logic [19:0] vramAddr_t;

    // pins of the async sram apart from data
    typedef struct packed {
        vramAddr_t address;
        logic      chipEnableN;
        logic      outputEnableN;
        logic      writeEnableN;
    } sramBus_t;

    // one pixel waiting for the writer
    typedef struct packed {
        logic      pending;
        vramAddr_t address;
        rgb565_t   pixel;
    } writeRequest_t;

endpackage

`default_nettype wire

/* hw/syncGenerator.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480 timing, 800 clocks by 525 lines
// position is the live count, sync lags it by one clock
// scanAddress is only meaningful while visible
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "videoCard_defs.svh"

module syncGenerator (
    input  wire                          clock,
    input  wire                          RESET,
    output videoTimingPkg::screenPos_t   position,
    output videoTimingPkg::syncOut_t     sync,
    output vramBusPkg::vramAddr_t        scanAddress
);
    logic [10:0] hCount;
    logic [9:0]  vCount;
    logic        lineEnd;
    logic        frameEnd;
    logic        pixelVisible;
    logic        hsyncActive;
    logic        vsyncActive;

    assign lineEnd      = (hCount == `H_TOTAL - 1);
    assign frameEnd     = lineEnd && (vCount == `V_TOTAL - 1);
    assign pixelVisible = (hCount < `H_VISIBLE) && (vCount < `V_VISIBLE);
    assign hsyncActive  = (hCount >= `H_SYNC_START) && (hCount < `H_SYNC_END);
    assign vsyncActive  = (vCount >= `V_SYNC_START) && (vCount < `V_SYNC_END);

    assign position = '{hCount: hCount, vCount: vCount};

    always_ff @(posedge clock or negedge RESET)
    begin
        if (!RESET)
        begin
            hCount <= '0;
            vCount <= '0;
        end
        else if (lineEnd)
        begin
            hCount <= '0;
            vCount <= frameEnd ? 10'd0 : vCount + 10'd1;   // wrap at 525
        end
        else
        begin
            hCount <= hCount + 11'd1;
        end
    end

    // pulses follow the count by one clock
    always_ff @(posedge clock or negedge RESET)
    begin
        if (!RESET)
            sync <= '{hsync: 1'b1, vsync: 1'b1, visible: 1'b0};
        else
            sync <= '{hsync: !hsyncActive, vsync: !vsyncActive, visible: pixelVisible};
    end

    // running twice (line * 640 + count), steps only on visible pixels
    // so it already holds the next line's start during blanking
    always_ff @(posedge clock or negedge RESET)
    begin
        if (!RESET)
            scanAddress <= '0;
        else if (frameEnd)
            scanAddress <= '0;
        else if (pixelVisible)
            scanAddress <= scanAddress + 20'd2;
    end

endmodule

`default_nettype wire

/* hw/pixelSource.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// test pattern or vram colour, black when blanked
// colour and sync leave two clocks after the count
// readData must already be one clock behind
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pixelSource (
    input  wire                          clock,
    input  wire                          RESET,
    input  wire videoTimingPkg::screenPos_t position,
    input  wire videoTimingPkg::syncOut_t   sync,
    input  wire                          vramMode,
    input  wire vramBusPkg::rgb565_t     readData,
    output vramBusPkg::rgb565_t          color,
    output logic                         hsync,
    output logic                         vsync
);
    import vramBusPkg::*;

    logic [15:0] scanIndex;     // line * 640 + count, low 16 bits
    logic [4:0]  greyLevel;
    logic        greyBand;
    rgb565_t     grey;
    rgb565_t     pattern;
    rgb565_t     patternDelayed;    // matches the read capture stage

    // 640 = 512 + 128
    assign scanIndex = {position.vCount[6:0], 9'd0} + {position.vCount[8:0], 7'd0}
                     + {5'd0, position.hCount};

    assign greyLevel = position.hCount[6:2];
    assign greyBand  = (position.hCount > 11'd512) && (position.hCount < 11'd640);
    assign grey      = '{red: greyLevel, green: {greyLevel, 1'b0}, blue: greyLevel};

    always_comb
    begin
        pattern = '0;
        if (position.vCount < 10'd240)
        begin
            // all 65536 colours across the top half
            pattern.red   = scanIndex[4:0];
            pattern.green = scanIndex[10:5];
            pattern.blue  = scanIndex[15:11];
        end
        else if (position.vCount < 10'd320)
        begin
            if (greyBand)
                pattern = grey;
            else
                pattern.red = position.hCount[8:4];     // red ramp
        end
        else if (position.vCount < 10'd400)
        begin
            if (greyBand)
                pattern = grey;
            else
                pattern.green = position.hCount[8:3];   // green ramp
        end
        else if (position.hCount > 11'd575)
            pattern = '0;                               // black tail
        else if (position.hCount > 11'd512)
            pattern = '1;                               // white block
        else
            pattern.blue = position.hCount[8:4];        // blue ramp
    end

    always_ff @(posedge clock)
    begin
        patternDelayed <= pattern;
    end

    // second stage, sync delayed once more to stay with the colour
    always_ff @(posedge clock or negedge RESET)
    begin
        if (!RESET)
        begin
            color <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end
        else
        begin
            if (!sync.visible)
                color <= '0;
            else
                color <= vramMode ? readData : patternDelayed;
            hsync <= sync.hsync;
            vsync <= sync.vsync;
        end
    end

endmodule

`default_nettype wire

/* hw/hostRegisters.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host byte stream, index byte then data byte
// every strobe is dropped while a pixel is pending
// unknown indices take their data byte and do nothing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "videoCard_defs.svh"

module hostRegisters (
    input  wire                          clock,
    input  wire                          RESET,
    input  wire                          hostByteValid,
    input  wire [7:0]                    hostByte,
    input  wire                          writeStart,
    output vramBusPkg::writeRequest_t    request,
    output logic                         vramMode
);
    import vramBusPkg::*;

    logic       dataPhase;      // next accepted byte is data
    logic [7:0] regIndex;
    logic       highStep;       // low pixel byte already held
    logic [7:0] lowByte;
    vramAddr_t  pointer;
    vramAddr_t  writeAddress;
    rgb565_t    writePixel;
    logic       pending;
    logic       accept;
    logic       pixelData;
    logic       lowTake;
    logic       pixelDone;

    assign accept    = hostByteValid && !pending;
    assign pixelData = accept && dataPhase && (regIndex == `REG_PIXEL);
    assign lowTake   = pixelData && !highStep;
    assign pixelDone = pixelData && highStep;

    assign request = '{pending: pending, address: writeAddress, pixel: writePixel};

    always_ff @(posedge clock or negedge RESET)
    begin
        if (!RESET)
        begin
            dataPhase <= 1'b0;
            regIndex  <= '0;
            highStep  <= 1'b0;
            pointer   <= '0;
            vramMode  <= 1'b0;
            pending   <= 1'b0;
        end
        else
        begin
            if (writeStart)
                pending <= 1'b0;        // writer has taken the pixel
            if (accept && !dataPhase)
            begin
                regIndex  <= hostByte;
                dataPhase <= 1'b1;
                highStep  <= 1'b0;
            end
            else if (accept)
            begin
                dataPhase <= lowTake;   // pixel register wants a second byte
                case (regIndex)
                    `REG_ADDR0:   pointer[7:0]   <= hostByte;
                    `REG_ADDR1:   pointer[15:8]  <= hostByte;
                    `REG_ADDR2:   pointer[19:16] <= hostByte[3:0];
                    `REG_CONTROL: vramMode       <= hostByte[0];
                    `REG_PIXEL:   highStep       <= !highStep;
                    default:      ;
                endcase
            end
            if (pixelDone)
            begin
                pending <= 1'b1;
                pointer <= pointer + 20'd2;     // next word
            end
        end
    end

    // pixel payload, address taken before the pointer moves
    always_ff @(posedge clock)
    begin
        if (lowTake)
            lowByte <= hostByte;
        if (pixelDone)
        begin
            writePixel   <= {hostByte, lowByte};
            writeAddress <= pointer;
        end
    end

endmodule

`default_nettype wire

/* hw/vramWriter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one sram write, we-controlled
// starts only inside the grant, lasts WRITE_CYCLES
// the bus window must outlast the grant by that much
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "videoCard_defs.svh"

module vramWriter (
    input  wire                           clock,
    input  wire                           RESET,
    input  wire vramBusPkg::writeRequest_t request,
    input  wire                           writeGrant,
    output logic                          writeStart,
    output logic                          busy,
    output logic                          writeEnableN,
    output logic                          writeChipEnableN
);
    logic [3:0] cycleCount;     // clocks left in the write

    assign busy       = (cycleCount != 4'd0);
    assign writeStart = request.pending && writeGrant && !busy;

    // ce low for the whole count, we low for the first WE_LOW_CYCLES
    assign writeChipEnableN = !busy;
    assign writeEnableN     = !(cycleCount > 4'(`WRITE_CYCLES - `WE_LOW_CYCLES));

    always_ff @(posedge clock or negedge RESET)
    begin
        if (!RESET)
            cycleCount <= '0;
        else if (writeStart)
            cycleCount <= 4'(`WRITE_CYCLES);
        else if (busy)
            cycleCount <= cycleCount - 4'd1;
    end

endmodule

`default_nettype wire

/* hw/vramPort.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sram bus split by screen position
// inside the bus window the writer owns the pins
// outside it the scan side reads with oe held low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "videoCard_defs.svh"

module vramPort (
    input  wire                             clock,
    input  wire                             RESET,
    input  wire videoTimingPkg::screenPos_t position,
    input  wire vramBusPkg::vramAddr_t      scanAddress,
    input  wire vramBusPkg::writeRequest_t  request,
    input  wire                             writeEnableN,
    input  wire                             writeChipEnableN,
    output logic                            writeGrant,
    output vramBusPkg::rgb565_t             readData,
    output vramBusPkg::sramBus_t            sramBus,
    inout  wire [15:0]                      vramData
);
    logic busWindow;
    logic scanActive;   // keeps reads off until reset is gone

    assign busWindow =
        (position.hCount >= `BUS_H_START && position.hCount < `BUS_H_END) ||
        (position.vCount >= `BUS_V_START && position.vCount < `BUS_V_END);

    // same start, earlier end
    assign writeGrant =
        (position.hCount >= `BUS_H_START && position.hCount < `GRANT_H_END) ||
        (position.vCount >= `BUS_V_START && position.vCount < `GRANT_V_END);

    always_comb
    begin
        if (busWindow)
        begin
            sramBus.address       = request.address;
            sramBus.chipEnableN   = writeChipEnableN;
            sramBus.outputEnableN = 1'b1;
            sramBus.writeEnableN  = writeEnableN;
        end
        else
        begin
            // address-controlled reads, one word per clock
            sramBus.address       = scanAddress;
            sramBus.chipEnableN   = !scanActive;
            sramBus.outputEnableN = !scanActive;
            sramBus.writeEnableN  = 1'b1;
        end
    end

    assign vramData = busWindow ? request.pixel : 16'bz;   // float while reading

    always_ff @(posedge clock or negedge RESET)
    begin
        if (!RESET)
            scanActive <= 1'b0;
        else
            scanActive <= 1'b1;
    end

    always_ff @(posedge clock)
    begin
        readData <= vramData;   // word for the previous count
    end

endmodule

`default_nettype wire

/* hw/videoCardTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vga card core with external async sram
// host must wait for pixelPending low between pixels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module videoCardTop (
    input  wire                    clock,
    input  wire                    RESET,
    input  wire                    hostByteValid,
    input  wire [7:0]              hostByte,
    output vramBusPkg::rgb565_t    color,
    output logic                   hsync,
    output logic                   vsync,
    output vramBusPkg::vramAddr_t  vramAddr,
    output logic                   vramChipEnableN,
    output logic                   vramOutputEnableN,
    output logic                   vramWriteEnableN,
    output logic                   pixelPending,
    inout  wire [15:0]             vramData
);
    import videoTimingPkg::*;
    import vramBusPkg::*;

    screenPos_t    position;
    syncOut_t      sync;
    vramAddr_t     scanAddress;
    writeRequest_t request;
    rgb565_t       readData;
    sramBus_t      sramBus;
    logic          vramMode;
    logic          writeGrant;
    logic          writeStart;
    logic          writerBusy;
    logic          writeEnableN;
    logic          writeChipEnableN;

    syncGenerator syncGen (
        .clock       (clock),
        .RESET       (RESET),
        .position    (position),
        .sync        (sync),
        .scanAddress (scanAddress)
    );

    pixelSource pixelSrc (
        .clock    (clock),
        .RESET    (RESET),
        .position (position),
        .sync     (sync),
        .vramMode (vramMode),
        .readData (readData),
        .color    (color),
        .hsync    (hsync),
        .vsync    (vsync)
    );

    hostRegisters hostRegs (
        .clock         (clock),
        .RESET         (RESET),
        .hostByteValid (hostByteValid),
        .hostByte      (hostByte),
        .writeStart    (writeStart),
        .request       (request),
        .vramMode      (vramMode)
    );

    vramWriter writer (
        .clock            (clock),
        .RESET            (RESET),
        .request          (request),
        .writeGrant       (writeGrant),
        .writeStart       (writeStart),
        .busy             (writerBusy),
        .writeEnableN     (writeEnableN),
        .writeChipEnableN (writeChipEnableN)
    );

    vramPort port (
        .clock            (clock),
        .RESET            (RESET),
        .position         (position),
        .scanAddress      (scanAddress),
        .request          (request),
        .writeEnableN     (writeEnableN),
        .writeChipEnableN (writeChipEnableN),
        .writeGrant       (writeGrant),
        .readData         (readData),
        .sramBus          (sramBus),
        .vramData         (vramData)
    );

    assign vramAddr          = sramBus.address;
    assign vramChipEnableN   = sramBus.chipEnableN;
    assign vramOutputEnableN = sramBus.outputEnableN;
    assign vramWriteEnableN  = sramBus.writeEnableN;

    // stays up until the sram cycle is over, not just until it starts
    assign pixelPending = request.pending || writerBusy;

endmodule

`default_nettype wire

/* tests/sramModel.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// async 16-bit sram, byte addressed, bit 0 ignored
// zero delay, writes land on the we rising edge
// every word starts random from fillSeed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sramModel #(
    parameter int fillSeed = 1
) (
    input  wire        [19:0] address,
    input  wire               chipEnableN,
    input  wire               outputEnableN,
    input  wire               writeEnableN,
    inout  wire        [15:0] data,
    output int                writeCount,     // writes seen so far
    output logic       [19:0] lastAddress,
    output logic       [15:0] lastData
);
    logic [15:0] mem [0:524287];     // 512k words
    int          fillState;

    // drive only for a plain read
    assign data = (chipEnableN === 1'b0 && outputEnableN === 1'b0 && writeEnableN === 1'b1)
                ? mem[address[19:1]] : 16'bz;

    initial
    begin
        writeCount = 0;
        fillState  = fillSeed;
        void'($urandom(fillState));    // seeds this thread once
        for (int i = 0; i < 524288; i++)
            mem[i] = 16'($urandom);
    end

    // we-controlled write, data and address taken at the end of the pulse
    always @(posedge writeEnableN)
    begin
        if (chipEnableN === 1'b0)
        begin
            mem[address[19:1]] <= data;
            lastAddress        <= address;
            lastData           <= data;
            writeCount         <= writeCount + 1;
        end
    end

endmodule

`default_nettype wire

/* tests/videoCardTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// card testbench, records from tests/videoCard_tests.txt
// position model is clocks since reset release
// output colour and sync lag that count by two clocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "videoCard_defs.svh"

module videoCardTb;
    import vramBusPkg::*;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int PIPE_LAG     = 2;                        // count to colour
    localparam int WAIT_LIMIT   = FRAME_CYCLES + `H_TOTAL;
    localparam int MAX_WORDS    = 256;

    logic        clock;
    logic        RESET;
    logic        hostByteValid;
    logic [7:0]  hostByte;
    rgb565_t     color;
    logic        hsync;
    logic        vsync;
    vramAddr_t   vramAddr;
    logic        vramChipEnableN;
    logic        vramOutputEnableN;
    logic        vramWriteEnableN;
    logic        pixelPending;
    wire  [15:0] vramData;
    int          writeCount;
    vramAddr_t   lastAddress;
    logic [15:0] lastData;

    int          tick;              // clocks since reset release
    int          mismatches;
    int          otherFailures;
    int          writesSeen;
    int          lastHFall;
    int          lastVFall;
    int          vsyncFalls;
    int          weLowCount;
    int          ceLowCount;
    logic        prevHsync;
    logic        prevVsync;
    bit          checkPattern;      // off once vram display is selected
    logic [19:0] testWords [0:MAX_WORDS-1];

    videoCardTop uut (
        .clock             (clock),
        .RESET             (RESET),
        .hostByteValid     (hostByteValid),
        .hostByte          (hostByte),
        .color             (color),
        .hsync             (hsync),
        .vsync             (vsync),
        .vramAddr          (vramAddr),
        .vramChipEnableN   (vramChipEnableN),
        .vramOutputEnableN (vramOutputEnableN),
        .vramWriteEnableN  (vramWriteEnableN),
        .pixelPending      (pixelPending),
        .vramData          (vramData)
    );

    sramModel #(.fillSeed(41776)) vram (
        .address       (vramAddr),
        .chipEnableN   (vramChipEnableN),
        .outputEnableN (vramOutputEnableN),
        .writeEnableN  (vramWriteEnableN),
        .data          (vramData),
        .writeCount    (writeCount),
        .lastAddress   (lastAddress),
        .lastData      (lastData)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;   // 4 ns

    always @(posedge clock or negedge RESET)
    begin
        if (!RESET)
            tick <= 0;
        else
            tick <= tick + 1;
    end

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        mismatches++;
        $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, expected);
    endtask

    task automatic reportFailure(input string what);
        otherFailures++;
        $display("[ERROR] %0d ns: %s", $time, what);
    endtask

    // frame phase of the count, lag clocks ago
    function automatic int lagPhase(input int lag);
        return (tick - lag) % FRAME_CYCLES;
    endfunction

    // built-in pattern, visible area only
    function automatic logic [15:0] patternColor(input int x, input int y);
        logic [15:0] index;
        logic [10:0] hx;
        logic [4:0]  grey;
        logic        greyBand;
        index    = 16'(y * `H_VISIBLE + x);
        hx       = 11'(x);
        grey     = hx[6:2];
        greyBand = (x >= 513) && (x <= 639);
        if (y < 240)
            return {index[4:0], index[10:5], index[15:11]};    // red from low bits
        if (y < 400 && greyBand)
            return {grey, grey, 1'b0, grey};
        if (y < 320)
            return {hx[8:4], 11'd0};
        if (y < 400)
            return {5'd0, hx[8:3], 5'd0};
        if (x > 575)
            return 16'h0000;
        if (x >= 513)
            return 16'hFFFF;
        return {11'd0, hx[8:4]};
    endfunction

    always @(negedge clock)
    begin : outputMonitor
        int          outPhase;
        int          outX;
        int          outY;
        int          busX;
        int          busY;
        logic        busWindow;
        logic [15:0] expected;
        if (RESET === 1'b1 && tick >= PIPE_LAG)
        begin
            outPhase = lagPhase(PIPE_LAG);
            outX     = outPhase % `H_TOTAL;
            outY     = outPhase / `H_TOTAL;
            busX     = tick % `H_TOTAL;                // live count, drives the bus
            busY     = (tick / `H_TOTAL) % `V_TOTAL;
            if (prevHsync && !hsync)
            begin
                assert (outX == `H_SYNC_START) else reportMismatch("hsync fall count", outX,
                                                                   `H_SYNC_START);
                if (lastHFall >= 0)
                begin
                    assert (tick - lastHFall == `H_TOTAL)
                        else reportMismatch("hsync period", tick - lastHFall, `H_TOTAL);
                end
                lastHFall = tick;
            end
            if (!prevHsync && hsync && lastHFall >= 0)
            begin
                assert (tick - lastHFall == `H_SYNC_END - `H_SYNC_START)
                    else reportMismatch("hsync low", tick - lastHFall, `H_SYNC_END - `H_SYNC_START);
            end
            if (prevVsync && !vsync)
            begin
                assert (outY == `V_SYNC_START && outX == 0)
                    else reportMismatch("vsync fall line", outY, `V_SYNC_START);
                if (lastVFall >= 0)
                begin
                    assert (tick - lastVFall == FRAME_CYCLES)
                        else reportMismatch("vsync period", tick - lastVFall, FRAME_CYCLES);
                end
                lastVFall = tick;
                vsyncFalls++;
            end
            if (!prevVsync && vsync && lastVFall >= 0)
            begin
                assert (tick - lastVFall == (`V_SYNC_END - `V_SYNC_START) * `H_TOTAL)
                    else reportMismatch("vsync low", tick - lastVFall,
                                        (`V_SYNC_END - `V_SYNC_START) * `H_TOTAL);
            end
            prevHsync = hsync;
            prevVsync = vsync;
            if (checkPattern)
            begin
                expected = (outX < `H_VISIBLE && outY < `V_VISIBLE) ? patternColor(outX, outY)
                                                                   : 16'h0000;
                assert (color === expected) else reportMismatch("color", color, expected);
            end
            busWindow = (busX >= `BUS_H_START && busX < `BUS_H_END) ||
                        (busY >= `BUS_V_START && busY < `BUS_V_END);
            if (busWindow)
            begin
                assert (vramOutputEnableN === 1'b1)
                    else reportMismatch("vramOutputEnableN", vramOutputEnableN, 1);
            end
            else
            begin
                assert (vramWriteEnableN === 1'b1)
                    else reportMismatch("vramWriteEnableN", vramWriteEnableN, 1);
            end
            // we pulse width in clocks
            if (vramWriteEnableN === 1'b0)
                weLowCount++;
            else if (weLowCount != 0)
            begin
                assert (weLowCount == `WE_LOW_CYCLES)
                    else reportMismatch("we low cycles", weLowCount, `WE_LOW_CYCLES);
                weLowCount = 0;
            end
            // ce pulse width inside the write window
            if (busWindow && vramChipEnableN === 1'b0)
                ceLowCount++;
            else if (ceLowCount != 0)
            begin
                assert (ceLowCount == `WRITE_CYCLES)
                    else reportMismatch("ce low cycles", ceLowCount, `WRITE_CYCLES);
                ceLowCount = 0;
            end
        end
    end

    task automatic sendByte(input logic [7:0] value);
        @(posedge clock);
        #1;
        hostByteValid = 1'b1;
        hostByte      = value;
        @(posedge clock);
        #1;
        hostByteValid = 1'b0;
    endtask

    // host rule, nothing new until the last pixel is stored
    task automatic sendWhenIdle(input logic [7:0] value);
        int waited;
        waited = 0;
        while (pixelPending !== 1'b0 && waited < FRAME_CYCLES)
        begin
            @(negedge clock);
            waited++;
        end
        if (pixelPending !== 1'b0)
            reportFailure("pixelPending did not fall within one frame");
        sendByte(value);
    endtask

    task automatic checkWrite(input vramAddr_t address, input logic [15:0] value);
        int waited;
        waited = 0;
        while (writeCount == writesSeen && waited < WAIT_LIMIT)
        begin
            @(negedge clock);
            waited++;
        end
        if (writeCount == writesSeen)
            reportFailure("no SRAM write seen for the expected pixel");
        else
        begin
            assert (lastAddress === address) else reportMismatch("vramAddr", lastAddress, address);
            assert (lastData === value) else reportMismatch("vramData", lastData, value);
            writesSeen = writeCount;
        end
    endtask

    // waits on the live count or on the output position
    task automatic waitPhase(input int lag, input int line, input int count, output bit found);
        int waited;
        waited = 0;
        @(negedge clock);
        while (lagPhase(lag) != line * `H_TOTAL + count && waited < WAIT_LIMIT)
        begin
            @(negedge clock);
            waited++;
        end
        found = (lagPhase(lag) == line * `H_TOTAL + count);
        if (!found)
            reportFailure("screen position never reached");
    endtask

    initial
    begin : stimulus
        int          rec;
        int          waited;
        int          line;
        logic [19:0] kind;
        logic [19:0] a;
        logic [19:0] b;
        logic [19:0] c;
        bit          found;
        RESET         = 1'b0;
        hostByteValid = 1'b0;
        hostByte      = 8'h00;
        checkPattern  = 1'b1;
        mismatches    = 0;
        otherFailures = 0;
        writesSeen    = 0;
        lastHFall     = -1;
        lastVFall     = -1;
        vsyncFalls    = 0;
        weLowCount    = 0;
        ceLowCount    = 0;
        prevHsync     = 1'b1;
        prevVsync     = 1'b1;
        $readmemh("tests/videoCard_tests.txt", testWords);
        repeat (5) @(posedge clock);
        #1;
        RESET = 1'b1;
        rec  = 0;
        kind = testWords[0];
        while (kind !== 20'h0 && kind !== 'x && rec < MAX_WORDS / 4)
        begin
            a = testWords[4 * rec + 1];
            b = testWords[4 * rec + 2];
            c = testWords[4 * rec + 3];
            case (kind)
                20'h1:
                begin
                    sendWhenIdle(a[7:0]);
                    sendWhenIdle(b[7:0]);
                end
                20'h2:
                begin
                    sendWhenIdle(`REG_PIXEL);
                    sendWhenIdle(a[7:0]);      // low byte first
                    sendWhenIdle(b[7:0]);
                end
                20'h3:
                begin
                    assert (pixelPending === 1'b1)
                        else reportMismatch("pixelPending", pixelPending, 1);
                    sendByte(a[7:0]);
                end
                20'h4: checkWrite(a, b[15:0]);
                20'h5:
                begin
                    checkPattern = 1'b0;
                    sendWhenIdle(a[7:0]);
                    sendWhenIdle(b[7:0]);
                    waitPhase(PIPE_LAG, 0, 0, found);   // a whole frame in the new mode
                end
                20'h6:
                begin
                    waitPhase(PIPE_LAG, a, b, found);
                    if (found)
                    begin
                        assert (color === c[15:0]) else reportMismatch("color", color, c[15:0]);
                    end
                end
                20'h7:
                begin
                    // start of some visible line, grant stays shut for 642 clocks
                    line = (lagPhase(0) / `H_TOTAL + 1) % `V_TOTAL;
                    if (line >= `V_VISIBLE)
                        line = 0;
                    waitPhase(0, line, 0, found);
                end
                default: reportFailure("unknown record kind in the test file");
            endcase
            rec++;
            kind = testWords[4 * rec];
        end
        if (kind !== 20'h0)
            reportFailure("test file has no end record");
        waited = 0;
        while (vsyncFalls < 2 && waited < 2 * WAIT_LIMIT)
        begin
            @(negedge clock);
            waited++;
        end
        if (vsyncFalls < 2)
            reportFailure("fewer than two vsync pulses seen");
        $display("errors: %0d mismatches, %0d other failures", mismatches, otherFailures);
        if (mismatches == 0 && otherFailures == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+hw
hw/videoTimingPkg.sv
hw/vramBusPkg.sv
hw/syncGenerator.sv
hw/pixelSource.sv
hw/hostRegisters.sv
hw/vramWriter.sv
hw/vramPort.sv
hw/videoCardTop.sv
tests/sramModel.sv
tests/videoCardTb.sv

/* tests/videoCard_tests.txt */
// kind a b c (hex): 1 reg index+data, 2 pixel lo hi, 3 byte sent while pending,
// 4 expected write addr value, 5 display select index+data, 6 scan line count value, 7 line start, 0 end
1 B0 28 0
1 B1 32 0
2 00 F8 0
4 03228 F800 0
7 0 0 0
2 E0 07 0
3 B3 0 0
3 01 0 0
4 0322A 07E0 0
1 B0 B0 0
1 B1 E0 0
1 B2 05 0
2 1F 00 0
4 5E0B0 001F 0
1 B0 FE 0
1 B1 5F 0
1 B2 09 0
2 C3 A5 0
4 95FFE A5C3 0
5 B3 01 0
6 00A 014 F800
6 00A 015 07E0
6 12C 258 001F
6 1DF 27F A5C3
0 0 0 0
